// File: hw/cmt_defs.svh
////////////////////
// Sizes of the two-slot commit stage
// CMT_CW must equal 1 << CMT_P_COMMIT_WIDTH
// PCs are word addresses, so CMT_PC_W is CMT_DW minus 2
////////////////////
`ifndef CMT_DEFS_SVH
`define CMT_DEFS_SVH

// Commit width
`define CMT_P_COMMIT_WIDTH 1
`define CMT_CW 2

// Datapath
`define CMT_DW 32
`define CMT_PC_W 30
`define CMT_PRF_AW 6

// Local data memory, 16 words
`define CMT_DMEM_P_WORDS 4

// Single exception entry point (word PC)
`define CMT_EXC_VECTOR 30'h0000_0040

`endif

// File: hw/cmt_pkg.sv
////////////////////
// Types shared by the commit stage and its testbench
// All widths come from cmt_defs.svh
////////////////////
`include "cmt_defs.svh"

package cmt_pkg;

   typedef logic [`CMT_PC_W-1:0]           pc_t;        // Word PC
   typedef logic [`CMT_DW-1:0]             data_t;
   typedef logic [`CMT_PRF_AW-1:0]         prf_addr_t;
   typedef logic [`CMT_P_COMMIT_WIDTH:0]   pop_t;       // 0 up to CMT_CW

   typedef enum logic [1:0] {LSU_NONE = 2'd0, LSU_LOAD = 2'd1, LSU_STORE = 2'd2} lsu_op_t;
   typedef enum logic [1:0] {EPU_NONE = 2'd0, EPU_RDEPC = 2'd1, EPU_ERET = 2'd2} epu_op_t;

   // Long-operation tracking in the commit selector
   typedef enum logic {S_IDLE = 1'b0, S_PENDING = 1'b1} cmt_state_t;

   // One reorder-buffer entry as seen at commit
   typedef struct packed {
      pc_t        pc;
      prf_addr_t  prd;
      logic       prd_we;
      logic       fls;            // Branch was mispredicted
      logic       exc;            // Exception raised upstream
      logic       is_bcc;
      logic       is_brel;
      logic       is_breg;
      lsu_op_t    lsu_op;
      epu_op_t    epu_op;
      data_t      opera;          // Byte address or real branch target
      data_t      operb;          // Store data
      logic       pred_taken;
      pc_t        pred_tgt;
   } cmt_slot_t;

   typedef cmt_slot_t [`CMT_CW-1:0] cmt_bundle_t;   // Slot 0 is the oldest

   typedef struct packed {
      logic       we;
      prf_addr_t  waddr;
      data_t      wdata;
   } prf_wb_t;

   typedef struct packed {
      logic       valid;
      logic       is_bcc;
      logic       is_breg;
      logic       is_brel;
      logic       taken;
      pc_t        pc;
      pc_t        npc_act;        // Resolved next PC
   } bpu_wb_t;

endpackage

// File: hw/cmt_sel.sv
////////////////////
// Only slot 0 may start a load, store or exception operation
// LSU and EPU must answer exactly one cycle after the request strobe
////////////////////
`timescale 1ns/100ps
`include "cmt_defs.svh"

module cmt_sel
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [`CMT_CW-1:0]          cmt_valid,
   input  cmt_pkg::cmt_bundle_t        cmt_slots,
   input  logic                        se_fls,
   input  cmt_pkg::pc_t                se_tgt,
   input  logic                        exc_flush,
   input  cmt_pkg::pc_t                exc_flush_tgt,
   input  logic                        lsu_wb_valid,
   input  cmt_pkg::data_t              lsu_wb_dout,
   input  logic                        epu_wb_valid,
   input  cmt_pkg::data_t              epu_wb_dout,
   output logic [`CMT_CW-1:0]          cmt_fire,
   output cmt_pkg::pop_t               cmt_pop_size,
   output logic                        flush,
   output cmt_pkg::pc_t                flush_tgt,
   output logic                        lsu_req_valid,
   output logic                        epu_req_valid,
   output cmt_pkg::prf_wb_t            prf_wb
);
   cmt_pkg::cmt_state_t                state_ff;
   cmt_pkg::cmt_state_t                state_nxt;
   logic [`CMT_CW-1:0]                 lsu_need;
   logic [`CMT_CW-1:0]                 epu_need;
   logic [`CMT_CW-1:0]                 single_fu;
   logic [`CMT_CW-1:0]                 cmt_mask;
   logic                               pipe_req;
   logic                               pipe_finish;

   always_comb
   begin
      for (int i = 0; i < `CMT_CW; i++)
      begin
         lsu_need[i] = (cmt_slots[i].lsu_op != cmt_pkg::LSU_NONE) & ~cmt_slots[i].exc;
         epu_need[i] = (cmt_slots[i].epu_op != cmt_pkg::EPU_NONE) | cmt_slots[i].exc;
         single_fu[i] = lsu_need[i] | epu_need[i] | cmt_slots[i].fls |
                        cmt_slots[i].is_bcc | cmt_slots[i].is_brel | cmt_slots[i].is_breg;
      end
   end

   assign pipe_req = cmt_valid[0] & ~se_fls & (lsu_need[0] | epu_need[0]);
   assign pipe_finish = lsu_wb_valid | epu_wb_valid;

   assign lsu_req_valid = (state_ff == cmt_pkg::S_IDLE) & pipe_req & lsu_need[0];
   assign epu_req_valid = (state_ff == cmt_pkg::S_IDLE) & pipe_req & epu_need[0];

   always_comb
   begin
      state_nxt = state_ff;
      case (state_ff)
         cmt_pkg::S_IDLE:
            if (pipe_req)
               state_nxt = cmt_pkg::S_PENDING;
         cmt_pkg::S_PENDING:
            if (pipe_finish)
               state_nxt = cmt_pkg::S_IDLE;
         default:
            state_nxt = cmt_pkg::S_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state_ff <= cmt_pkg::S_IDLE;
      else
         state_ff <= state_nxt;
   end

   // Mispredict flush wins over the exception flush
   assign flush = se_fls | exc_flush;
   assign flush_tgt = se_fls ? se_tgt : exc_flush_tgt;

   // In-order commit mask, each slot needs the one before it
   always_comb
   begin
      cmt_mask[0] = (~pipe_req | pipe_finish) & ~flush;
      cmt_fire[0] = cmt_valid[0] & cmt_mask[0];
      for (int i = 1; i < `CMT_CW; i++)
      begin
         cmt_mask[i] = cmt_fire[i-1] & ~single_fu[i];
         cmt_fire[i] = cmt_valid[i] & cmt_mask[i];
      end
   end

   always_comb
   begin
      cmt_pop_size = '0;
      for (int i = 0; i < `CMT_CW; i++)
         cmt_pop_size = cmt_pop_size + cmt_pkg::pop_t'(cmt_fire[i]);
   end

   assign prf_wb = '{we:    pipe_finish & ~flush & cmt_slots[0].prd_we,
                     waddr: cmt_slots[0].prd,
                     wdata: epu_wb_valid ? epu_wb_dout : lsu_wb_dout};

endmodule

// File: hw/cmt_bru.sv
////////////////////
// Branch side of commit. Only slot 0 may hold a branch at commit
// The mispredict flush follows the firing cycle and lasts one cycle
////////////////////
`timescale 1ns/100ps
`include "cmt_defs.svh"

module cmt_bru
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [`CMT_CW-1:0]          cmt_fire,
   input  cmt_pkg::cmt_slot_t          slot0,
   output logic                        se_fls,
   output cmt_pkg::pc_t                se_tgt,
   output cmt_pkg::bpu_wb_t            bpu_wb
);
   logic                               is_b;

   assign is_b = slot0.is_bcc | slot0.is_brel | slot0.is_breg;

   always_ff @(posedge clk)
   begin
      if (rst)
         se_fls <= 1'b0;
      else
         se_fls <= cmt_fire[0] & slot0.fls;     // One-cycle pulse
   end

   always_ff @(posedge clk)
   begin
      if (cmt_fire[0])
         se_tgt <= slot0.opera[`CMT_PC_W-1:0];  // Real target of the branch
   end

   // Predictor update for a committed branch
   assign bpu_wb = '{valid:   cmt_fire[0] & is_b,
                     is_bcc:  slot0.is_bcc,
                     is_breg: slot0.is_breg,
                     is_brel: slot0.is_brel,
                     taken:   slot0.pred_taken ^ slot0.fls,
                     pc:      slot0.pc,
                     npc_act: slot0.fls ? slot0.opera[`CMT_PC_W-1:0] : slot0.pred_tgt};

endmodule

// File: hw/cmt_lsu.sv
////////////////////
// Word-wide local data memory in place of the data bus
// Addresses are byte addresses and wrap at the memory size
// No alignment check. The low byte bits are ignored
////////////////////
`timescale 1ns/100ps
`include "cmt_defs.svh"

module cmt_lsu
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        lsu_req_valid,
   input  cmt_pkg::cmt_slot_t          slot0,
   output logic                        lsu_wb_valid,
   output cmt_pkg::data_t              lsu_wb_dout
);
   localparam int DEPTH   = 1 << `CMT_DMEM_P_WORDS;
   localparam int P_BYTES = $clog2(`CMT_DW / 8);

   cmt_pkg::data_t                     mem [0:DEPTH-1];
   logic [`CMT_DMEM_P_WORDS-1:0]       idx;

   assign idx = slot0.opera[`CMT_DMEM_P_WORDS+P_BYTES-1:P_BYTES];

   always_ff @(posedge clk)
   begin
      if (lsu_req_valid)
      begin
         if (slot0.lsu_op == cmt_pkg::LSU_STORE)
            mem[idx] <= slot0.operb;
         // Stores answer with zero
         lsu_wb_dout <= (slot0.lsu_op == cmt_pkg::LSU_LOAD) ? mem[idx] : '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         lsu_wb_valid <= 1'b0;
      else
         lsu_wb_valid <= lsu_req_valid;         // Fixed one-cycle latency
   end

endmodule

// File: hw/cmt_epu.sv
////////////////////
// Exception unit with a single vector and one EPC register
// An exception takes priority over the opcode of the same entry
// EPC holds a word PC and reads back zero-extended
////////////////////
`timescale 1ns/100ps
`include "cmt_defs.svh"

module cmt_epu
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        epu_req_valid,
   input  cmt_pkg::cmt_slot_t          slot0,
   output logic                        epu_wb_valid,
   output cmt_pkg::data_t              epu_wb_dout,
   output logic                        exc_flush,
   output cmt_pkg::pc_t                exc_flush_tgt
);
   cmt_pkg::pc_t                       epc;
   logic                               exc_take;
   logic                               is_eret;

   assign exc_take = epu_req_valid & slot0.exc;
   assign is_eret = (slot0.epu_op == cmt_pkg::EPU_ERET);

   always_ff @(posedge clk)
   begin
      if (rst)
         epc <= '0;
      else if (exc_take)
         epc <= slot0.pc;                       // Return point is the faulting entry
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         epu_wb_valid <= 1'b0;
         exc_flush <= 1'b0;
      end
      else
      begin
         epu_wb_valid <= epu_req_valid;
         exc_flush <= epu_req_valid & (slot0.exc | is_eret);
      end
   end

   always_ff @(posedge clk)
   begin
      if (epu_req_valid)
      begin
         exc_flush_tgt <= slot0.exc ? `CMT_EXC_VECTOR : epc;
         if (slot0.epu_op == cmt_pkg::EPU_RDEPC)
            epu_wb_dout <= {{(`CMT_DW-`CMT_PC_W){1'b0}}, epc};
         else
            epu_wb_dout <= '0;
      end
   end

endmodule

// File: hw/cmt.sv
////////////////////
// Commit stage top. The reorder buffer holds entries until they fire
// flush drops every entry the buffer still presents
////////////////////
`timescale 1ns/100ps
`include "cmt_defs.svh"

module cmt
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [`CMT_CW-1:0]          cmt_valid,
   input  cmt_pkg::cmt_bundle_t        cmt_slots,
   output logic [`CMT_CW-1:0]          cmt_fire,
   output cmt_pkg::pop_t               cmt_pop_size,
   output logic                        flush,
   output cmt_pkg::pc_t                flush_tgt,
   output cmt_pkg::prf_wb_t            prf_wb,
   output cmt_pkg::bpu_wb_t            bpu_wb
);
   logic                               se_fls;
   cmt_pkg::pc_t                       se_tgt;
   logic                               lsu_req_valid;
   logic                               lsu_wb_valid;
   cmt_pkg::data_t                     lsu_wb_dout;
   logic                               epu_req_valid;
   logic                               epu_wb_valid;
   cmt_pkg::data_t                     epu_wb_dout;
   logic                               exc_flush;
   cmt_pkg::pc_t                       exc_flush_tgt;

   cmt_sel u_sel
   (
      .clk (clk), .rst (rst),
      .cmt_valid (cmt_valid), .cmt_slots (cmt_slots),
      .se_fls (se_fls), .se_tgt (se_tgt),
      .exc_flush (exc_flush), .exc_flush_tgt (exc_flush_tgt),
      .lsu_wb_valid (lsu_wb_valid), .lsu_wb_dout (lsu_wb_dout),
      .epu_wb_valid (epu_wb_valid), .epu_wb_dout (epu_wb_dout),
      .cmt_fire (cmt_fire), .cmt_pop_size (cmt_pop_size),
      .flush (flush), .flush_tgt (flush_tgt),
      .lsu_req_valid (lsu_req_valid), .epu_req_valid (epu_req_valid),
      .prf_wb (prf_wb)
   );

   cmt_bru u_bru
   (
      .clk (clk), .rst (rst),
      .cmt_fire (cmt_fire), .slot0 (cmt_slots[0]),
      .se_fls (se_fls), .se_tgt (se_tgt), .bpu_wb (bpu_wb)
   );

   // LSU and EPU only ever serve slot 0
   cmt_lsu u_lsu
   (
      .clk (clk), .rst (rst),
      .lsu_req_valid (lsu_req_valid), .slot0 (cmt_slots[0]),
      .lsu_wb_valid (lsu_wb_valid), .lsu_wb_dout (lsu_wb_dout)
   );

   cmt_epu u_epu
   (
      .clk (clk), .rst (rst),
      .epu_req_valid (epu_req_valid), .slot0 (cmt_slots[0]),
      .epu_wb_valid (epu_wb_valid), .epu_wb_dout (epu_wb_dout),
      .exc_flush (exc_flush), .exc_flush_tgt (exc_flush_tgt)
   );

endmodule

// File: tests/cmt_props.sv
////////////////////
// Commit rules checked on every clock outside reset
////////////////////
`timescale 1ns/100ps
`include "cmt_defs.svh"

module cmt_props
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [`CMT_CW-1:0]          cmt_fire,
   input  cmt_pkg::pop_t               cmt_pop_size,
   input  logic                        flush,
   input  cmt_pkg::prf_wb_t            prf_wb
);

   a_in_order: assert property (@(posedge clk) disable iff (rst) cmt_fire[1] |-> cmt_fire[0])
      else $error("slot 1 fired without slot 0");

   a_no_fire_on_flush: assert property (@(posedge clk) disable iff (rst) flush |-> cmt_fire == '0)
      else $error("an entry fired during a flush");

   a_pop_count: assert property (@(posedge clk) disable iff (rst)
                                 32'(cmt_pop_size) == $countones(cmt_fire))
      else $error("pop size differs from the number of fired slots");

   a_no_wb_on_flush: assert property (@(posedge clk) disable iff (rst) !(prf_wb.we && flush))
      else $error("register writeback during a flush");

endmodule

bind cmt cmt_props u_props
(
   .clk (clk), .rst (rst),
   .cmt_fire (cmt_fire), .cmt_pop_size (cmt_pop_size),
   .flush (flush), .prf_wb (prf_wb)
);

// File: tests/cmt_tb.sv
////////////////////
// Reorder-buffer model driven from tests/cmt_golden.txt
// Entry after a mispredicted branch is a plain delay-slot entry
// Wrong-path lines follow every flushing entry
////////////////////
`timescale 1ns/100ps
`include "cmt_defs.svh"

module cmt_tb;
   localparam int NF = 18;                      // Columns per golden entry
   localparam int MAXE = 32;
   localparam int F_PC = 0, F_PRD = 1, F_WE = 2, F_FLS = 3, F_EXC = 4, F_BCC = 5,
                  F_BREL = 6, F_BREG = 7, F_LSU = 8, F_EPU = 9, F_OPA = 10, F_OPB = 11,
                  F_PTK = 12, F_PTGT = 13, F_WP = 14, F_EWA = 15, F_EWD = 16, F_EFT = 17;

   logic                               clk = 1'b0;
   logic                               rst;
   logic [`CMT_CW-1:0]                 cmt_valid;
   cmt_pkg::cmt_bundle_t               cmt_slots;
   logic [`CMT_CW-1:0]                 cmt_fire;
   cmt_pkg::pop_t                      cmt_pop_size;
   logic                               flush;
   cmt_pkg::pc_t                       flush_tgt;
   cmt_pkg::prf_wb_t                   prf_wb;
   cmt_pkg::bpu_wb_t                   bpu_wb;

   logic [31:0]                        gold [0:NF*MAXE];
   int                                 n;
   int                                 head = 0;       // Oldest live entry
   int                                 age = 0;        // Cycles the head has sat at slot 0
   int                                 cycles = 0;
   logic                               mis_pending = 1'b0;
   logic [31:0]                        mis_tgt = '0;

   cmt uut
   (
      .clk (clk), .rst (rst),
      .cmt_valid (cmt_valid), .cmt_slots (cmt_slots),
      .cmt_fire (cmt_fire), .cmt_pop_size (cmt_pop_size),
      .flush (flush), .flush_tgt (flush_tgt),
      .prf_wb (prf_wb), .bpu_wb (bpu_wb)
   );

   always #5 clk = ~clk;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped");
   endtask

   task automatic check_eq(input string what, input logic [31:0] expv, input logic [31:0] actv);
      assert (actv === expv)
      else fail_run($sformatf("mismatch %s: expected %0h, actual %0h", what, expv, actv));
   endtask

   function automatic logic [31:0] fld(input int e, input int f);
      return gold[1 + e * NF + f];
   endfunction

   function automatic logic flag(input int e, input int f);
      return fld(e, f) != 0;
   endfunction

   function automatic logic is_long(input int e);
      return (fld(e, F_LSU) != 0) || (fld(e, F_EPU) != 0) || flag(e, F_EXC);
   endfunction

   function automatic logic is_branch(input int e);
      return flag(e, F_BCC) || flag(e, F_BREL) || flag(e, F_BREG);
   endfunction

   function automatic logic single_unit(input int e);
      return is_long(e) || flag(e, F_FLS) || is_branch(e);
   endfunction

   function automatic cmt_pkg::cmt_slot_t slot_of(input int e);
      cmt_pkg::cmt_slot_t s;
      s = '0;
      if (e < n)
      begin
         s.pc = cmt_pkg::pc_t'(fld(e, F_PC));
         s.prd = cmt_pkg::prf_addr_t'(fld(e, F_PRD));
         s.prd_we = flag(e, F_WE);
         s.fls = flag(e, F_FLS);
         s.exc = flag(e, F_EXC);
         s.is_bcc = flag(e, F_BCC);
         s.is_brel = flag(e, F_BREL);
         s.is_breg = flag(e, F_BREG);
         s.lsu_op = cmt_pkg::lsu_op_t'(2'(fld(e, F_LSU)));
         s.epu_op = cmt_pkg::epu_op_t'(2'(fld(e, F_EPU)));
         s.opera = fld(e, F_OPA);
         s.operb = fld(e, F_OPB);
         s.pred_taken = flag(e, F_PTK);
         s.pred_tgt = cmt_pkg::pc_t'(fld(e, F_PTGT));
      end
      return s;
   endfunction

   task automatic drive_rob();
      cmt_valid <= {head + 1 < n, head < n};
      cmt_slots <= {slot_of(head + 1), slot_of(head)};
   endtask

   task automatic check_quiet(input string what);
      check_eq({what, " fire"}, 32'h0, 32'(cmt_fire));
      check_eq({what, " flush"}, 32'h0, 32'(flush));
      check_eq({what, " prf we"}, 32'h0, 32'(prf_wb.we));
      check_eq({what, " bpu valid"}, 32'h0, 32'(bpu_wb.valid));
   endtask

   // Checks one commit cycle, then moves the model on
   task automatic step_rob();
      logic long0;
      logic eflush;
      logic ef0;
      logic ef1;
      logic ewe;
      logic ebv;
      logic [31:0] etgt;
      string tn;
      tn = $sformatf("entry %0d", head);
      long0 = (head < n) && is_long(head);
      eflush = mis_pending || (long0 && age == 1 && (flag(head, F_EXC) || fld(head, F_EPU) == 2));
      etgt = mis_pending ? mis_tgt : fld(head, F_EFT);
      ef0 = (head < n) && !eflush && (!long0 || age == 1);    // Long ops answer after one cycle
      ef1 = ef0 && (head + 1 < n) && !single_unit(head + 1);
      ewe = ef0 && long0 && flag(head, F_WE);
      ebv = ef0 && is_branch(head);
      check_eq({tn, " flush"}, 32'(eflush), 32'(flush));
      if (eflush)
         check_eq({tn, " flush_tgt"}, etgt, 32'(flush_tgt));
      check_eq({tn, " fire"}, {30'b0, ef1, ef0}, 32'(cmt_fire));
      check_eq({tn, " pop size"}, 32'(ef0) + 32'(ef1), 32'(cmt_pop_size));
      check_eq({tn, " prf we"}, 32'(ewe), 32'(prf_wb.we));
      if (ewe)
      begin
         check_eq({tn, " prf waddr"}, fld(head, F_EWA), 32'(prf_wb.waddr));
         check_eq({tn, " prf wdata"}, fld(head, F_EWD), prf_wb.wdata);
      end
      check_eq({tn, " bpu valid"}, 32'(ebv), 32'(bpu_wb.valid));
      if (ebv)
      begin
         check_eq({tn, " bpu taken"}, 32'(flag(head, F_PTK) ^ flag(head, F_FLS)),
                  32'(bpu_wb.taken));
         check_eq({tn, " bpu npc"}, flag(head, F_FLS) ? (fld(head, F_OPA) & 32'h3fff_ffff) :
                  fld(head, F_PTGT), 32'(bpu_wb.npc_act));
         check_eq({tn, " bpu pc"}, fld(head, F_PC), 32'(bpu_wb.pc));
         check_eq({tn, " bpu bcc"}, 32'(flag(head, F_BCC)), 32'(bpu_wb.is_bcc));
         check_eq({tn, " bpu brel"}, 32'(flag(head, F_BREL)), 32'(bpu_wb.is_brel));
         check_eq({tn, " bpu breg"}, 32'(flag(head, F_BREG)), 32'(bpu_wb.is_breg));
      end
      mis_pending = ef0 && flag(head, F_FLS);
      if (mis_pending)
         mis_tgt = fld(head, F_EFT);
      if (flush)
      begin
         if (head < n && !flag(head, F_WP))
            head++;                             // Excepting entry is discarded too
         while (head < n && flag(head, F_WP))
            head++;
         age = 0;
      end
      else if (cmt_pop_size != 0)
      begin
         head = head + int'(cmt_pop_size);
         age = 0;
      end
      else
         age++;
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= 20 * n)
         fail_run($sformatf("timeout: commit stream not done after %0d cycles", cycles));
   end

   initial
   begin
      rst <= 1'b1;
      cmt_valid <= '0;
      cmt_slots <= '0;
      $readmemh("tests/cmt_golden.txt", gold);
      n = int'(gold[0]);
      if (n <= 0 || n > MAXE)
         fail_run("golden file is missing or holds a bad entry count");
      repeat (2)
      begin
         @(negedge clk);
         check_quiet("reset");
      end
      @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_quiet("reset");
      @(posedge clk);
      @(negedge clk);
      check_quiet("after reset");               // Buffer still empty here
      @(posedge clk);
      drive_rob();
      while (head < n)
      begin
         @(negedge clk);
         step_rob();
         @(posedge clk);
         drive_rob();
      end
      @(negedge clk);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: tests/cmt_golden.txt
// First value is the entry count. Every later line is one entry, all hex:
// pc prd we fls exc bcc brel breg lsu epu opera operb ptk ptgt wp ewa ewd eft
14
10 01 1 0 0 0 0 0 0 0 00000000 00000000 0 00 0 00 00000000 00
11 02 1 0 0 0 0 0 0 0 00000000 00000000 0 00 0 00 00000000 00
12 03 0 0 0 0 0 0 0 0 00000000 00000000 0 00 0 00 00000000 00
13 00 0 0 0 0 0 0 2 0 00000024 deadbeef 0 00 0 00 00000000 00
14 05 1 0 0 0 0 0 1 0 00000024 00000000 0 00 0 05 deadbeef 00
15 06 1 0 0 0 0 0 0 0 00000000 00000000 0 00 0 00 00000000 00
16 00 0 0 0 1 0 0 0 0 00000030 00000000 1 30 0 00 00000000 00
17 00 0 0 0 0 0 0 0 0 00000000 00000000 0 00 0 00 00000000 00
30 00 0 1 0 0 1 0 0 0 00000050 00000000 0 31 0 00 00000000 50
31 04 1 0 0 0 0 0 0 0 00000000 00000000 0 00 0 00 00000000 00
32 00 0 0 0 0 0 0 2 0 00000024 00000bad 0 00 1 00 00000000 00
33 00 0 0 0 0 0 0 0 0 00000000 00000000 0 00 1 00 00000000 00
50 07 1 0 0 0 0 0 1 0 00000024 00000000 0 00 0 07 deadbeef 00
51 08 1 0 1 0 0 0 0 0 00000000 00000000 0 00 0 00 00000000 40
52 00 0 0 0 0 0 0 0 0 00000000 00000000 0 00 1 00 00000000 00
40 09 1 0 0 0 0 0 0 1 00000000 00000000 0 00 0 09 00000051 00
41 00 0 0 0 0 0 0 0 2 00000000 00000000 0 00 0 00 00000000 51
42 00 0 0 0 0 0 0 0 0 00000000 00000000 0 00 1 00 00000000 00
51 0a 1 0 0 0 0 0 0 0 00000000 00000000 0 00 0 00 00000000 00
52 0b 1 0 0 0 0 0 0 0 00000000 00000000 0 00 0 00 00000000 00

// File: verilog.f
+incdir+hw
hw/cmt_pkg.sv
hw/cmt_sel.sv
hw/cmt_bru.sv
hw/cmt_lsu.sv
hw/cmt_epu.sv
hw/cmt.sv
tests/cmt_props.sv
tests/cmt_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module cmt_tb -o cmt_sim || exit 1
./obj_dir/cmt_sim > sim.log 2>&1
cat sim.log
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
